// File: include/des_config.svh
`ifndef DES_CONFIG_SVH
`define DES_CONFIG_SVH

// Feistel rounds in one DES block
`define DES_ROUNDS 16

// Rounds chained combinationally per clock
`define DES_UNROLL 2

// Clock cycles that carry rounds
`define DES_PASSES (`DES_ROUNDS / `DES_UNROLL)

// Pass index width, enough for DES_PASSES values
`define DES_PASS_W 3

`endif

// File: design/des_pkg.sv
package des_pkg;

	`include "des_config.svh"

	// Bit 1 is the MSB throughout, as in the DES tables
	typedef logic [1:64] block_t;    // Message, result, permuted block
	typedef logic [1:64] key_t;      // Raw key incl. parity bits
	typedef logic [1:32] half_t;     // Feistel half, L or R
	typedef logic [1:48] subkey_t;   // Round key after PC-2
	typedef logic [1:28] cd_t;       // C or D half of key register

	// Index of current round pair
	typedef logic [`DES_PASS_W-1:0] pass_t;

	// Round core control
	typedef enum logic [1:0] {
		IDLE,    // Waiting for start
		ROUNDS,  // Two rounds per cycle
		FINISH   // Hand off to output stage
	} core_state_t;

endpackage

// File: design/des_key_schedule.sv
`timescale 1ns/1ps

`include "des_config.svh"

module des_key_schedule (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load,      // Start accepted, take PC-1(key)
	input  logic            advance,   // Round pair applied this cycle
	input  des_pkg::pass_t  pass,
	input  des_pkg::key_t   key,
	output des_pkg::subkey_t subkey_a,  // Round 2*pass+1
	output des_pkg::subkey_t subkey_b   // Round 2*pass+2
);

	import des_pkg::*;

	// PC-1, drops parity bits, 56 bits out
	localparam int unsigned PC1_TAB [0:55] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
	};

	// PC-2, picks 48 of the 56 C/D bits
	localparam int unsigned PC2_TAB [0:47] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
	};

	// Left rotation per round, rounds 1..16
	localparam int unsigned SHIFT_TAB [0:15] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	cd_t c_q, d_q;         // C/D state, as left after previous pass
	cd_t c_a, d_a;         // After first rotation of this pass
	cd_t c_b, d_b;         // After second rotation
	int unsigned shift_a;
	int unsigned shift_b;

	function automatic logic [1:56] pc1(input key_t k);
		logic [1:56] y;
		for (int i = 0; i < 56; i++) begin
			y[i+1] = k[PC1_TAB[i]];
		end
		return y;
	endfunction

	function automatic subkey_t pc2(input cd_t c, input cd_t d);
		logic [1:56] cd;
		subkey_t     y;
		cd = {c, d};
		for (int i = 0; i < 48; i++) begin
			y[i+1] = cd[PC2_TAB[i]];
		end
		return y;
	endfunction

	// Only 1 or 2 positions ever occur
	function automatic cd_t rotl(input cd_t x, input int unsigned n);
		return (n == 1) ? {x[2:28], x[1]} : {x[3:28], x[1:2]};
	endfunction

	assign shift_a = SHIFT_TAB[`DES_UNROLL * int'(pass)];
	assign shift_b = SHIFT_TAB[`DES_UNROLL * int'(pass) + 1];

	always_comb begin
		c_a = rotl(c_q, shift_a);
		d_a = rotl(d_q, shift_a);
		c_b = rotl(c_a, shift_b);  // Cumulative, second round of the pair
		d_b = rotl(d_a, shift_b);
	end

	assign subkey_a = pc2(c_a, d_a);
	assign subkey_b = pc2(c_b, d_b);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			c_q <= '0;
			d_q <= '0;
		end else if (load) begin
			{c_q, d_q} <= pc1(key);  // C0/D0
		end else if (advance) begin
			c_q <= c_b;  // Ready for next pair
			d_q <= d_b;
		end
	end

endmodule

// File: design/des_round.sv
`timescale 1ns/1ps

module des_round (
	input  des_pkg::half_t   l_in,
	input  des_pkg::half_t   r_in,
	input  des_pkg::subkey_t subkey,
	output des_pkg::half_t   l_out,
	output des_pkg::half_t   r_out
);

	import des_pkg::*;

	// Expansion E, 32 to 48 bits
	localparam int unsigned E_TAB [0:47] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
	};

	// P permutation after the S-boxes
	localparam int unsigned P_TAB [0:31] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
	};

	// S1..S8, index is {row, col} with row = outer bits
	localparam logic [3:0] SBOX [0:7][0:63] = '{
		'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
		   0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
		   4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
		  15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
		'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
		   3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
		   0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
		  13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
		'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
		  13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
		  13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
		   1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
		'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
		  13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
		  10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
		   3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
		'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
		  14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
		   4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
		  11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
		'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
		  10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
		   9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
		   4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
		'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
		  13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
		   1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
		   6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
		'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
		   1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
		   7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
		   2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
	};

	subkey_t mixed;   // E(R) xor K
	half_t   s_out;   // Concatenated S-box outputs
	half_t   f_out;   // f(R, K)

	function automatic subkey_t expand(input half_t r);
		subkey_t y;
		for (int i = 0; i < 48; i++) begin
			y[i+1] = r[E_TAB[i]];
		end
		return y;
	endfunction

	function automatic half_t p_perm(input half_t x);
		half_t y;
		for (int i = 0; i < 32; i++) begin
			y[i+1] = x[P_TAB[i]];
		end
		return y;
	endfunction

	assign mixed = expand(r_in) ^ subkey;

	always_comb begin
		logic [5:0] six;
		for (int i = 0; i < 8; i++) begin
			six = mixed[6*i+1 +: 6];
			// Row from bits 1 and 6, column from bits 2..5
			s_out[4*i+1 +: 4] = SBOX[i][{six[5], six[0], six[4:1]}];
		end
	end

	assign f_out = p_perm(s_out);

	assign l_out = r_in;           // Halves swap every round
	assign r_out = l_in ^ f_out;

endmodule

// File: design/des_round_core.sv
`timescale 1ns/1ps

`include "des_config.svh"

module des_round_core (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             start,
	input  des_pkg::block_t  message,
	input  des_pkg::subkey_t subkey_a,
	input  des_pkg::subkey_t subkey_b,
	output logic             load,     // Start taken this cycle
	output logic             advance,  // ROUNDS cycle
	output logic             finish,   // L16/R16 ready
	output des_pkg::pass_t   pass,
	output des_pkg::half_t   final_l,
	output des_pkg::half_t   final_r
);

	import des_pkg::*;

	// Initial permutation
	localparam int unsigned IP_TAB [0:63] = '{
		58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
		57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
	};

	core_state_t state_q, state_d;
	pass_t       pass_q;
	block_t      ip_msg;
	half_t       l_q, r_q;     // Feistel state
	half_t       l_mid, r_mid; // Between round_a and round_b
	half_t       l_nxt, r_nxt;

	function automatic block_t ip(input block_t m);
		block_t y;
		for (int i = 0; i < 64; i++) begin
			y[i+1] = m[IP_TAB[i]];
		end
		return y;
	endfunction

	assign ip_msg = ip(message);

	// Control decode
	assign load    = (state_q == IDLE) && start;  // Busy starts dropped
	assign advance = (state_q == ROUNDS);
	assign finish  = (state_q == FINISH);
	assign pass    = pass_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:    if (start) state_d = ROUNDS;
			ROUNDS:  if (pass_q == pass_t'(`DES_PASSES - 1)) state_d = FINISH;  // Last pair
			FINISH:  state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			pass_q  <= '0;
		end else begin
			state_q <= state_d;
			if (load)
				pass_q <= '0;
			else if (advance)
				pass_q <= pass_q + 1'b1;  // Wraps to 0 after last pass
		end
	end

	// Two chained rounds per cycle
	des_round round_a (
		.l_in   (l_q),
		.r_in   (r_q),
		.subkey (subkey_a),
		.l_out  (l_mid),
		.r_out  (r_mid)
	);

	des_round round_b (
		.l_in   (l_mid),
		.r_in   (r_mid),
		.subkey (subkey_b),
		.l_out  (l_nxt),
		.r_out  (r_nxt)
	);

	// L/R register, L0/R0 then one round pair per cycle
	always_ff @(posedge clk) begin
		if (load)
			{l_q, r_q} <= ip_msg;  // L0/R0
		else if (advance)
			{l_q, r_q} <= {l_nxt, r_nxt};
	end

	assign final_l = l_q;
	assign final_r = r_q;

endmodule

// File: design/des_output_stage.sv
`timescale 1ns/1ps

module des_output_stage (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            finish,
	input  des_pkg::half_t  final_l,
	input  des_pkg::half_t  final_r,
	output logic            done,
	output des_pkg::block_t result
);

	import des_pkg::*;

	// Inverse of IP
	localparam int unsigned FP_TAB [0:63] = '{
		40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
		38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
		36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
		34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
	};

	block_t preout;  // R16 followed by L16
	block_t cipher;

	function automatic block_t fp(input block_t x);
		block_t y;
		for (int i = 0; i < 64; i++) begin
			y[i+1] = x[FP_TAB[i]];
		end
		return y;
	endfunction

	assign preout = {final_r, final_l};  // Undo last swap
	assign cipher = fp(preout);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done   <= 1'b0;
			result <= '0;
		end else begin
			done <= finish;  // FINISH lasts one cycle
			if (finish)
				result <= cipher;  // Held until next block
		end
	end

endmodule

// File: design/des_encryptor.sv
`timescale 1ns/1ps

module des_encryptor (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,    // One-cycle strobe
	input  des_pkg::block_t message,
	input  des_pkg::key_t   key,
	output logic            done,     // Nine edges after start
	output des_pkg::block_t result
);

	import des_pkg::*;

	logic    load, advance, finish;
	pass_t   pass;
	subkey_t subkey_a, subkey_b;
	half_t   final_l, final_r;

	// Input side
	des_key_schedule u_key_schedule (
		.clk      (clk),
		.rst_n    (rst_n),
		.load     (load),
		.advance  (advance),
		.pass     (pass),
		.key      (key),
		.subkey_a (subkey_a),
		.subkey_b (subkey_b)
	);

	des_round_core u_round_core (
		.clk      (clk),
		.rst_n    (rst_n),
		.start    (start),
		.message  (message),
		.subkey_a (subkey_a),
		.subkey_b (subkey_b),
		.load     (load),
		.advance  (advance),
		.finish   (finish),
		.pass     (pass),
		.final_l  (final_l),
		.final_r  (final_r)
	);

	// Output side
	des_output_stage u_output_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.finish  (finish),
		.final_l (final_l),
		.final_r (final_r),
		.done    (done),
		.result  (result)
	);

endmodule

// File: test/des_encryptor_assertions.sv
`timescale 1ns/1ps

module des_encryptor_assertions (
	input logic clk,
	input logic rst_n,
	input logic load,
	input logic advance,
	input logic finish,
	input logic done
);

	int failures = 0;  // Read by the testbench top

	// Single-cycle done pulse
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
		else begin
			$error("done held high for two cycles");
			failures++;
		end

	// Accepted start, then 9 quiet edges, then done
	done_latency: assert property (@(posedge clk) disable iff (!rst_n)
		load |=> (!done) [*9] ##1 done)
		else begin
			$error("done not nine cycles after accepted start");
			failures++;
		end

	// ROUNDS and FINISH are exclusive
	advance_finish: assert property (@(posedge clk) disable iff (!rst_n)
		!(advance && finish))
		else begin
			$error("advance and finish high together");
			failures++;
		end

endmodule

bind des_encryptor des_encryptor_assertions u_assertions (
	.clk     (clk),
	.rst_n   (rst_n),
	.load    (load),
	.advance (advance),
	.finish  (finish),
	.done    (done)
);

// File: test/des_encryptor_tb.sv
`timescale 1ns/1ps

module des_encryptor_tb;

	localparam int TIMEOUT_CYCLES = 20;  // Per wait for done
	localparam int LATENCY = 9;          // Edges from start to done

	// Standard DES tables, positions counted from 1 at the MSB
	localparam int IP_T [64] = '{
		58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
		62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
		57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
		61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7};
	localparam int E_T [48] = '{
		32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,  8,  9, 10, 11,
		12, 13, 12, 13, 14, 15, 16, 17, 16, 17, 18, 19, 20, 21, 20, 21,
		22, 23, 24, 25, 24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1};
	localparam int P_T [32] = '{
		16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25};
	localparam int PC1_T [56] = '{
		57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4};
	localparam int PC2_T [48] = '{
		14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10, 23, 19, 12,  4,
		26,  8, 16,  7, 27, 20, 13,  2, 41, 52, 31, 37, 47, 55, 30, 40,
		51, 45, 33, 48, 44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32};
	localparam int SHIFT_T [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};
	// One row per entry, 16 nibbles from column 0, four rows per S-box
	localparam logic [63:0] SBOX_ROWS [32] = '{
		64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538, 64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D,
		64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5, 64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9,
		64'hA09E63F51DC7B428, 64'hD709346A285ECBF1, 64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C,
		64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9, 64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E,
		64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986, 64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453,
		64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38, 64'h9EF528C3704A1DB6, 64'h432C95FABE17608D,
		64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86, 64'h14BDC37EAF680592, 64'h6BD814A7950FE23C,
		64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92, 64'h7B419CE206ADF358, 64'h21E74A8DFC90356B};

	logic        clk;
	logic        rst_n;
	logic        start;
	logic [63:0] message;
	logic [63:0] key;
	logic        done;
	logic [63:0] result;

	logic [63:0] rng;       // xorshift state
	int          errors;
	int          test_count;
	int          pass_count;

	des_encryptor DUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.message (message),
		.key     (key),
		.done    (done),
		.result  (result)
	);

	always #5 clk = ~clk;  // 10 ns period

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	// Reference encryption, bit position p lives at index width-p
	function automatic logic [63:0] des_model(input logic [63:0] msg, input logic [63:0] k);
		logic [55:0] cd;     // C in [55:28], D in [27:0]
		logic [63:0] blk;
		logic [47:0] sk;
		logic [47:0] ex;
		logic [31:0] l, r, s, f, t;
		logic [5:0]  six;
		logic [63:0] res;
		int          row;
		int          col;
		for (int i = 0; i < 56; i++)
			cd[55-i] = k[64-PC1_T[i]];
		for (int i = 0; i < 64; i++)
			blk[63-i] = msg[64-IP_T[i]];
		l = blk[63:32];
		r = blk[31:0];
		for (int rnd = 0; rnd < 16; rnd++) begin
			for (int j = 0; j < SHIFT_T[rnd]; j++)
				cd = {cd[54:28], cd[55], cd[26:0], cd[27]};  // Both halves rotate left
			for (int i = 0; i < 48; i++)
				sk[47-i] = cd[56-PC2_T[i]];
			for (int i = 0; i < 48; i++)
				ex[47-i] = r[32-E_T[i]];
			ex = ex ^ sk;
			for (int b = 0; b < 8; b++) begin
				six = ex[47-6*b -: 6];
				row = {six[5], six[0]};  // Outer bits
				col = six[4:1];
				s[31-4*b -: 4] = SBOX_ROWS[4*b+row][63-4*col -: 4];
			end
			for (int i = 0; i < 32; i++)
				f[31-i] = s[32-P_T[i]];
			t = r;
			r = l ^ f;
			l = t;
		end
		blk = {r, l};  // Last swap undone
		// Final permutation as inverse of IP
		for (int i = 0; i < 64; i++)
			res[64-IP_T[i]] = blk[63-i];
		return res;
	endfunction

	task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
		assert (act === exp) else begin
			$display("FAILED %s: expected %h, got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit ok, input string what);
		assert (ok) else begin
			$display("%s", what);
			errors++;
		end
	endtask

	// Called at a falling edge, returns at the falling edge after E0
	task automatic start_block(input logic [63:0] msg, input logic [63:0] k);
		start = 1'b1;
		message = msg;
		key = k;
		@(negedge clk);
		start = 1'b0;
	endtask

	// Counts rising edges until done is seen, bounded
	task automatic wait_done(output int edges, output bit timed_out);
		edges = 0;
		timed_out = 1'b1;
		while (edges < TIMEOUT_CYCLES) begin
			@(negedge clk);
			edges++;
			if (done) begin
				timed_out = 1'b0;
				break;
			end
		end
	endtask

	// One block end to end, ends in the done cycle
	task automatic run_block(input logic [63:0] msg, input logic [63:0] k, input string name);
		int edges;
		bit timed_out;
		start_block(msg, k);
		wait_done(edges, timed_out);
		check_true(!timed_out, $sformatf("%s: no done within %0d cycles", name, TIMEOUT_CYCLES));
		if (!timed_out) begin
			check_value("latency", edges, LATENCY);  // Counted from E1
			check_value("result", result, des_model(msg, k));
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		test_count++;
		if (errors == err_before) begin
			pass_count++;
			$display("%-24s ok", name);
		end else begin
			$display("%-24s %0d check(s) wrong", name, errors - err_before);
		end
	endtask

	initial begin
		logic [63:0] m, k, m2, k2, held;
		int          err_before;
		int          edges;
		bit          timed_out;
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		message = '0;
		key = '0;
		rng = 64'd71;
		errors = 0;
		test_count = 0;
		pass_count = 0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;

		err_before = errors;
		@(negedge clk);
		check_value("done", done, 1'b0);
		check_value("result", result, '0);
		finish_test("after reset", err_before);

		err_before = errors;
		check_value("model", des_model(64'h0123456789ABCDEF, 64'h133457799BBCDFF1),
			64'h85E813540F0AB405);  // Model against the textbook vector
		run_block(64'h0123456789ABCDEF, 64'h133457799BBCDFF1, "known answer");
		check_value("result", result, 64'h85E813540F0AB405);
		@(negedge clk);
		finish_test("known answer", err_before);

		err_before = errors;
		for (int n = 0; n < 200; n++) begin
			rng = xorshift64(rng);
			k = rng;
			rng = xorshift64(rng);
			m = rng;
			run_block(m, k, "random");
			@(negedge clk);
			check_value("done", done, 1'b0);  // Pulse width
		end
		finish_test("random blocks", err_before);

		err_before = errors;
		rng = xorshift64(rng);
		m = rng;
		rng = xorshift64(rng);
		k = rng;
		run_block(m, k, "latency");
		@(negedge clk);
		check_value("done", done, 1'b0);
		finish_test("fixed latency", err_before);

		err_before = errors;
		rng = xorshift64(rng);
		m = rng;
		rng = xorshift64(rng);
		k = rng;
		m2 = ~m;          // Different data for the dropped start
		k2 = k ^ 64'hFF;
		start_block(m, k);
		start_block(m2, k2);  // Lands in ROUNDS
		wait_done(edges, timed_out);
		check_true(!timed_out, "busy: no done after first block");
		check_value("latency", edges + 1, LATENCY);  // E1 taken by the dropped start
		check_value("result", result, des_model(m, k));
		repeat (TIMEOUT_CYCLES) begin
			@(negedge clk);
			check_value("done", done, 1'b0);  // No done for the dropped start
		end
		finish_test("busy start ignored", err_before);

		err_before = errors;
		held = des_model(m, k);  // Still the busy test's first block
		repeat (5) begin
			@(negedge clk);
			check_value("result", result, held);
		end
		rng = xorshift64(rng);
		m = rng;
		rng = xorshift64(rng);
		k = rng;
		run_block(m, k, "first");
		run_block(m ^ k, k + 1, "back to back");  // Start in the done cycle
		@(negedge clk);
		check_value("done", done, 1'b0);
		finish_test("hold and back to back", err_before);

		check_true(DUT.u_assertions.failures == 0,
			$sformatf("%0d bound assertion failure(s) during the run",
				DUT.u_assertions.failures));

		$display("%0d tests, %0d passed, %0d failed, %0d failing checks",
			test_count, pass_count, test_count - pass_count, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+include
design/des_pkg.sv
design/des_key_schedule.sv
design/des_round.sv
design/des_round_core.sv
design/des_output_stage.sv
design/des_encryptor.sv
test/des_encryptor_assertions.sv
test/des_encryptor_tb.sv
